// File: design/csr_pkg.sv
/*
 * CSR subsystem shared definitions
 * Widths, the word-addressed register map, the identity constant and the
 * helpers that decode engine windows out of a word address
 */

package csr_pkg;

    // Bus and register widths
    localparam int addr_width = 12;
    localparam int data_width = 32;
    localparam int word_addr_width = 10;
    localparam int num_engines = 2;

    typedef logic [word_addr_width-1:0] t_csr_addr;
    typedef logic [data_width-1:0] t_csr_data;

    // Value returned by the read-only identity register
    localparam t_csr_data csr_id_value = 32'h4353_5231;

    // Global register word offsets
    localparam t_csr_addr reg_id = 10'd0;
    localparam t_csr_addr reg_scratch = 10'd1;
    localparam t_csr_addr reg_num_eng = 10'd2;

    // Engine windows start at word 64 and repeat every 64 words
    localparam int eng_base = 64;
    localparam int eng_span = 64;

    // Register offsets inside one engine window
    localparam int eng_reg_width = 2;
    localparam logic [eng_reg_width-1:0] eng_acc = 2'd0;
    localparam logic [eng_reg_width-1:0] eng_add = 2'd1;
    localparam logic [eng_reg_width-1:0] eng_count = 2'd2;

    // Drops the byte lane bits of an AXI-lite address
    function automatic t_csr_addr byte_to_word(logic [addr_width-1:0] byte_addr);
        return byte_addr[addr_width-1:addr_width-word_addr_width];
    endfunction

    // True when the word address falls inside the window of engine idx
    function automatic logic in_eng_window(t_csr_addr addr, int unsigned idx);
        int unsigned word;
        int unsigned base;
        word = addr;
        base = eng_base + idx * eng_span;
        return (word >= base) && (word < base + eng_span);
    endfunction

    // Register offset carried to an engine
    function automatic logic [eng_reg_width-1:0] eng_offset(t_csr_addr addr);
        return addr[eng_reg_width-1:0];
    endfunction

    // Only the first few words of a window reach the engine
    function automatic logic eng_offset_mapped(t_csr_addr addr);
        int unsigned word;
        word = addr;
        return (word % eng_span) < (2 ** eng_reg_width);
    endfunction

endpackage

// File: design/engine_csr_if.sv
/*
 * Engine CSR link
 * Carries register writes from the CSR manager into one accumulator engine
 * and brings the engine state back for reads
 */

`timescale 1ns/1ns

interface engine_csr_if;
    import csr_pkg::*;

    // Single-cycle write strobe with the register offset in the window
    logic wr_en;
    logic [eng_reg_width-1:0] wr_reg;
    t_csr_data wr_data;

    // Engine state, always visible so the manager can pick a field itself
    t_csr_data acc;
    t_csr_data count;

    modport csr_mgr
    (
        output wr_en,
        output wr_reg,
        output wr_data,
        input  acc,
        input  count
    );

    modport engine
    (
        input  wr_en,
        input  wr_reg,
        input  wr_data,
        output acc,
        output count
    );

endinterface

// File: design/axi_lite_csr_bridge.sv
/*
 * AXI-lite to CSR bridge
 * Holds write address and data until both are present, then issues one
 * write strobe and a registered write response. Reads are limited to one
 * in flight and the result is held until the host takes it
 */

`timescale 1ns/1ns

module axi_lite_csr_bridge
(
    input  logic clk,
    input  logic reset_n,

    input  logic awvalid,
    output logic awready,
    input  logic [csr_pkg::addr_width-1:0] awaddr,

    input  logic wvalid,
    output logic wready,
    input  csr_pkg::t_csr_data wdata,

    output logic bvalid,
    input  logic bready,

    input  logic arvalid,
    output logic arready,
    input  logic [csr_pkg::addr_width-1:0] araddr,

    output logic rvalid,
    input  logic rready,
    output csr_pkg::t_csr_data rdata,

    output logic wr_en,
    output csr_pkg::t_csr_addr wr_addr,
    output csr_pkg::t_csr_data wr_data,
    output logic rd_en,
    output csr_pkg::t_csr_addr rd_addr,
    input  logic rd_valid,
    input  csr_pkg::t_csr_data rd_data
);
    import csr_pkg::*;

    // Goes high the first cycle out of reset and opens all the ready signals
    logic accept_en;

    // Holding registers for the split write channels
    logic aw_held;
    logic w_held;
    t_csr_addr aw_addr_q;
    t_csr_data w_data_q;

    // Set from the AR transfer until the R transfer
    logic rd_busy;

    logic aw_fire;
    logic w_fire;
    logic ar_fire;

    // A channel stays closed while its holding register is full or while
    // the previous write is still waiting on its response
    assign awready = accept_en && !aw_held && !bvalid;
    assign wready = accept_en && !w_held && !bvalid;
    assign arready = accept_en && !rd_busy;

    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;
    assign ar_fire = arvalid && arready;

    // One write strobe per joined address and data pair
    assign wr_en = aw_held && w_held && !bvalid;
    assign wr_addr = aw_addr_q;
    assign wr_data = w_data_q;

    // The read goes to the manager in the same cycle as the AR transfer
    assign rd_en = ar_fire;
    assign rd_addr = byte_to_word(araddr);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            accept_en <= 1'b0;
            aw_held <= 1'b0;
            w_held <= 1'b0;
            bvalid <= 1'b0;
        end
        else
        begin
            accept_en <= 1'b1;

            if (aw_fire)
                aw_held <= 1'b1;
            if (w_fire)
                w_held <= 1'b1;

            // The response is registered, so bvalid never follows bready
            if (bvalid && bready)
                bvalid <= 1'b0;

            // Both holding registers empty once the write has been issued
            if (wr_en)
            begin
                aw_held <= 1'b0;
                w_held <= 1'b0;
                bvalid <= 1'b1;
            end
        end
    end

    // Write payload captured as each channel transfers
    always_ff @(posedge clk)
    begin
        if (aw_fire)
            aw_addr_q <= byte_to_word(awaddr);
        if (w_fire)
            w_data_q <= wdata;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_busy <= 1'b0;
            rvalid <= 1'b0;
        end
        else
        begin
            if (ar_fire)
                rd_busy <= 1'b1;

            // Manager result arrives one cycle after rd_en
            if (rd_valid)
                rvalid <= 1'b1;

            // arready reopens the cycle after the host takes the data
            if (rvalid && rready)
            begin
                rvalid <= 1'b0;
                rd_busy <= 1'b0;
            end
        end
    end

    // Read data stays put while rvalid waits on rready
    always_ff @(posedge clk)
    begin
        if (rd_valid)
            rdata <= rd_data;
    end

endmodule

// File: design/csr_mgr.sv
/*
 * CSR manager
 * Decodes word addresses, keeps the global registers, routes writes into
 * the two engine windows and turns every read into a registered result
 */

`timescale 1ns/1ns

module csr_mgr
(
    input  logic clk,
    input  logic reset_n,

    input  logic wr_en,
    input  csr_pkg::t_csr_addr wr_addr,
    input  csr_pkg::t_csr_data wr_data,

    input  logic rd_en,
    input  csr_pkg::t_csr_addr rd_addr,
    output logic rd_valid,
    output csr_pkg::t_csr_data rd_data,

    engine_csr_if.csr_mgr eng0,
    engine_csr_if.csr_mgr eng1
);
    import csr_pkg::*;

    // General purpose read/write register for the host
    t_csr_data scratch;

    // Write lands on one of the first words of some engine window
    logic wr_eng_mapped;

    // Read result before it is registered
    t_csr_data rd_next;

    // Picks the readable field of one engine by its register offset
    function automatic t_csr_data eng_field
    (
        logic [eng_reg_width-1:0] offset,
        t_csr_data acc,
        t_csr_data count
    );
        case (offset)
            eng_acc:   return acc;
            eng_count: return count;
            // The add register and the spare offset read back as zero
            default:   return '0;
        endcase
    endfunction

    assign wr_eng_mapped = wr_en && eng_offset_mapped(wr_addr);

    // Both engines see the same offset and data, only the strobe differs
    assign eng0.wr_en = wr_eng_mapped && in_eng_window(wr_addr, 0);
    assign eng0.wr_reg = eng_offset(wr_addr);
    assign eng0.wr_data = wr_data;

    assign eng1.wr_en = wr_eng_mapped && in_eng_window(wr_addr, 1);
    assign eng1.wr_reg = eng_offset(wr_addr);
    assign eng1.wr_data = wr_data;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            scratch <= '0;
        else if (wr_en && (wr_addr == reg_scratch))
            scratch <= wr_data;
    end

    // Read select works on the current register values, so a read that
    // meets a write to the same word sees the old contents
    always_comb
    begin
        rd_next = '0;

        if (rd_addr == reg_id)
            rd_next = csr_id_value;
        else if (rd_addr == reg_scratch)
            rd_next = scratch;
        else if (rd_addr == reg_num_eng)
            rd_next = t_csr_data'(num_engines);
        else if (eng_offset_mapped(rd_addr))
        begin
            if (in_eng_window(rd_addr, 0))
                rd_next = eng_field(eng_offset(rd_addr), eng0.acc, eng0.count);
            else if (in_eng_window(rd_addr, 1))
                rd_next = eng_field(eng_offset(rd_addr), eng1.acc, eng1.count);
        end
    end

    // Result comes back exactly one cycle after rd_en
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_en;
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= rd_next;
    end

endmodule

// File: design/accum_engine.sv
/*
 * Accumulator engine
 * Keeps a 32-bit running sum and counts the additions made since the sum
 * was last loaded by the host
 */

`timescale 1ns/1ns

module accum_engine
(
    input  logic clk,
    input  logic reset_n,

    engine_csr_if.engine csr
);
    import csr_pkg::*;

    // Running sum, wraps modulo 2^32
    t_csr_data acc_q;

    // Number of additions since the last load
    t_csr_data count_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            acc_q <= '0;
            count_q <= '0;
        end
        else if (csr.wr_en)
        begin
            case (csr.wr_reg)
                // A load starts a new sum, so the count starts over too
                eng_acc:
                begin
                    acc_q <= csr.wr_data;
                    count_q <= '0;
                end

                // Carry out of bit 31 is dropped
                eng_add:
                begin
                    acc_q <= acc_q + csr.wr_data;
                    count_q <= count_q + 1'b1;
                end

                // The count register is read-only and the spare offset
                // has no storage behind it
                default:
                begin
                    acc_q <= acc_q;
                    count_q <= count_q;
                end
            endcase
        end
    end

    // State goes back to the manager without any read strobe
    assign csr.acc = acc_q;
    assign csr.count = count_q;

endmodule

// File: design/csr_subsys_top.sv
/*
 * CSR subsystem top level
 * AXI-lite slave in front of the CSR manager and two accumulator engines
 */

`timescale 1ns/1ns

module csr_subsys_top
(
    input  logic clk,
    input  logic reset_n,

    input  logic awvalid,
    output logic awready,
    input  logic [csr_pkg::addr_width-1:0] awaddr,

    input  logic wvalid,
    output logic wready,
    input  csr_pkg::t_csr_data wdata,

    output logic bvalid,
    input  logic bready,
    output logic [1:0] bresp,

    input  logic arvalid,
    output logic arready,
    input  logic [csr_pkg::addr_width-1:0] araddr,

    output logic rvalid,
    input  logic rready,
    output csr_pkg::t_csr_data rdata,
    output logic [1:0] rresp
);
    import csr_pkg::*;

    // Strobes between the bridge and the manager
    logic wr_en;
    t_csr_addr wr_addr;
    t_csr_data wr_data;
    logic rd_en;
    t_csr_addr rd_addr;
    logic rd_valid;
    t_csr_data rd_data;

    engine_csr_if eng0_if();
    engine_csr_if eng1_if();

    // Every access completes, so both responses are always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    axi_lite_csr_bridge bridge
    (
        .clk,
        .reset_n,
        .awvalid,
        .awready,
        .awaddr,
        .wvalid,
        .wready,
        .wdata,
        .bvalid,
        .bready,
        .arvalid,
        .arready,
        .araddr,
        .rvalid,
        .rready,
        .rdata,
        .wr_en,
        .wr_addr,
        .wr_data,
        .rd_en,
        .rd_addr,
        .rd_valid,
        .rd_data
    );

    csr_mgr mgr
    (
        .clk,
        .reset_n,
        .wr_en,
        .wr_addr,
        .wr_data,
        .rd_en,
        .rd_addr,
        .rd_valid,
        .rd_data,
        .eng0(eng0_if.csr_mgr),
        .eng1(eng1_if.csr_mgr)
    );

    // Engine 0 sits at byte 0x100 and engine 1 at byte 0x200
    accum_engine eng0
    (
        .clk,
        .reset_n,
        .csr(eng0_if.engine)
    );

    accum_engine eng1
    (
        .clk,
        .reset_n,
        .csr(eng1_if.engine)
    );

endmodule

// File: verification/csr_subsys_tb.sv
/*
 * Testbench for the CSR subsystem
 * Replays the transactions of the cases file over AXI-lite with random
 * back-pressure on B and R, then checks write and read handshake timing
 */

`timescale 1ns/1ns

module csr_subsys_tb;

    // Longest wait for any handshake, in clock cycles
    localparam int wait_limit = 50;

    logic clk = 1'b0;
    logic reset_n;
    logic awvalid;
    logic awready;
    logic [11:0] awaddr;
    logic wvalid;
    logic wready;
    logic [31:0] wdata;
    logic bvalid;
    logic bready;
    logic [1:0] bresp;
    logic arvalid;
    logic arready;
    logic [11:0] araddr;
    logic rvalid;
    logic rready;
    logic [31:0] rdata;
    logic [1:0] rresp;

    integer seed;
    integer error_count;
    integer timeout_count;
    integer write_count;

    // When set, bready and rready follow $random, otherwise they stay high
    logic rand_ready;

    csr_subsys_top UUT
    (
        .clk(clk),
        .reset_n(reset_n),
        .awvalid(awvalid),
        .awready(awready),
        .awaddr(awaddr),
        .wvalid(wvalid),
        .wready(wready),
        .wdata(wdata),
        .bvalid(bvalid),
        .bready(bready),
        .bresp(bresp),
        .arvalid(arvalid),
        .arready(arready),
        .araddr(araddr),
        .rvalid(rvalid),
        .rready(rready),
        .rdata(rdata),
        .rresp(rresp)
    );

    initial
    begin
        forever #50 clk = ~clk;
    end

    // One ready value for the current cycle
    task ready_draw(output logic r);
        logic [31:0] rnd;
        if (rand_ready)
        begin
            rnd = $random(seed);
            r = rnd[0];
        end
        else
            r = 1'b1;
    endtask

    // AXI-lite write; with w_late set, W is raised one cycle after AW
    task write_word(input logic [8*24-1:0] name, input logic [11:0] addr,
                    input logic [31:0] data, input logic w_late);
        int cycles;
        logic aw_go;
        logic w_go;
        logic aw_done;
        logic w_done;
        logic b_done;
        awvalid = 1'b1;
        awaddr = addr;
        wdata = data;
        wvalid = !w_late;
        aw_done = 1'b0;
        w_done = 1'b0;
        cycles = 0;
        // Ready signals are registered, so their value at the falling edge
        // is the one the next rising edge sees
        while (!(aw_done && w_done) && cycles < wait_limit)
        begin
            aw_go = awvalid && awready;
            w_go = wvalid && wready;
            @(negedge clk);
            cycles++;
            if (aw_go)
            begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_go)
            begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
            if (!w_done)
                wvalid = 1'b1;
        end
        if (!aw_done)
        begin
            $display("Timeout in %0s: the write address channel never accepted", name);
            timeout_count++;
        end
        if (!w_done)
        begin
            $display("Timeout in %0s: the write data channel never accepted", name);
            timeout_count++;
        end
        awvalid = 1'b0;
        wvalid = 1'b0;

        b_done = 1'b0;
        cycles = 0;
        while (!b_done && cycles < wait_limit)
        begin
            ready_draw(bready);
            if (bvalid && bready)
            begin
                b_done = 1'b1;
                if (bresp !== 2'b00)
                begin
                    $display("ERROR %0s: expected bresp %h, actual %h", name, 2'b00, bresp);
                    error_count++;
                end
            end
            @(negedge clk);
            cycles++;
        end
        bready = 1'b0;
        if (!b_done)
        begin
            $display("Timeout in %0s: no write response arrived", name);
            timeout_count++;
        end
    endtask

    // AXI-lite read, returns the data of the R transfer
    task read_word(input logic [8*24-1:0] name, input logic [11:0] addr,
                   output logic [31:0] data);
        int cycles;
        logic ar_go;
        logic ar_done;
        logic r_done;
        arvalid = 1'b1;
        araddr = addr;
        ar_done = 1'b0;
        cycles = 0;
        while (!ar_done && cycles < wait_limit)
        begin
            ar_go = arready;
            @(negedge clk);
            cycles++;
            if (ar_go)
                ar_done = 1'b1;
            if (ar_go)
                arvalid = 1'b0;
        end
        arvalid = 1'b0;
        if (!ar_done)
        begin
            $display("Timeout in %0s: the read address channel never accepted", name);
            timeout_count++;
        end

        data = '0;
        r_done = 1'b0;
        cycles = 0;
        while (!r_done && cycles < wait_limit)
        begin
            ready_draw(rready);
            if (rvalid && rready)
            begin
                r_done = 1'b1;
                data = rdata;
                if (rresp !== 2'b00)
                begin
                    $display("ERROR %0s: expected rresp %h, actual %h", name, 2'b00, rresp);
                    error_count++;
                end
            end
            @(negedge clk);
            cycles++;
        end
        rready = 1'b0;
        if (!r_done)
        begin
            $display("Timeout in %0s: no read data arrived", name);
            timeout_count++;
        end
    endtask

    // Each non-comment line of the cases file is one transaction
    task run_cases;
        int fd;
        int n;
        int case_count;
        string line;
        logic [8*24-1:0] name;
        logic [7:0] op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] got;
        case_count = 0;
        fd = $fopen("verification/csr_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the cases file verification/csr_cases.txt");
            error_count++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%s %s %h %h", name, op, addr, data);
                    if (n == 4)
                    begin
                        case_count++;
                        if (op == "W")
                        begin
                            write_word(name, addr, data, write_count[0]);
                            write_count++;
                        end
                        else if (op == "R")
                        begin
                            read_word(name, addr, got);
                            if (got !== data)
                            begin
                                $display("ERROR %0s: expected %h, actual %h", name, data, got);
                                error_count++;
                            end
                        end
                        else
                        begin
                            $display("Case %0s has an unknown operation", name);
                            error_count++;
                        end
                    end
                end
            end
            $fclose(fd);
            if (case_count == 0)
            begin
                $display("The cases file held no transactions");
                error_count++;
            end
        end
    endtask

    // AW and W together with bready high, B should follow two cycles later
    task write_timing_check;
        int cycles;
        logic [31:0] got;
        awvalid = 1'b1;
        awaddr = 12'h004;
        wvalid = 1'b1;
        wdata = 32'h3c3c_a5a5;
        bready = 1'b1;
        cycles = 0;
        while (!(awready && wready) && cycles < wait_limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!(awready && wready))
        begin
            $display("Timeout in write_timing: address and data were never accepted together");
            timeout_count++;
            awvalid = 1'b0;
            wvalid = 1'b0;
        end
        else
        begin
            @(negedge clk);
            awvalid = 1'b0;
            wvalid = 1'b0;
            cycles = 1;
            while (!bvalid && cycles < wait_limit)
            begin
                @(negedge clk);
                cycles++;
            end
            if (!bvalid)
            begin
                $display("Timeout in write_timing: no write response arrived");
                timeout_count++;
            end
            else
            begin
                if (cycles != 2)
                begin
                    $display("ERROR write_timing: expected %0d, actual %0d", 2, cycles);
                    error_count++;
                end
                if (bresp !== 2'b00)
                begin
                    $display("ERROR write_timing: expected bresp %h, actual %h", 2'b00, bresp);
                    error_count++;
                end
            end
            @(negedge clk);
        end
        bready = 1'b0;
        read_word("write_timing_rd", 12'h004, got);
        if (got !== 32'h3c3c_a5a5)
        begin
            $display("ERROR write_timing_rd: expected %h, actual %h", 32'h3c3c_a5a5, got);
            error_count++;
        end
    endtask

    // With rready high, rvalid rises two cycles after AR and arready stays low
    task read_timing_check;
        int cycles;
        logic ar_open;
        arvalid = 1'b1;
        araddr = 12'h000;
        rready = 1'b1;
        ar_open = 1'b0;
        cycles = 0;
        while (!arready && cycles < wait_limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!arready)
        begin
            $display("Timeout in read_timing: the read address channel never accepted");
            timeout_count++;
        end
        else
        begin
            @(negedge clk);
            arvalid = 1'b0;
            cycles = 1;
            while (!rvalid && cycles < wait_limit)
            begin
                if (arready)
                    ar_open = 1'b1;
                @(negedge clk);
                cycles++;
            end
            if (!rvalid)
            begin
                $display("Timeout in read_timing: no read data arrived");
                timeout_count++;
            end
            else
            begin
                if (cycles != 2)
                begin
                    $display("ERROR read_timing: expected %0d, actual %0d", 2, cycles);
                    error_count++;
                end
                if (arready || ar_open)
                begin
                    $display("arready rose while a read was still in flight");
                    error_count++;
                end
                if (rdata !== 32'h4353_5231)
                begin
                    $display("ERROR read_timing: expected %h, actual %h", 32'h4353_5231, rdata);
                    error_count++;
                end
                if (rresp !== 2'b00)
                begin
                    $display("ERROR read_timing: expected rresp %h, actual %h", 2'b00, rresp);
                    error_count++;
                end
                @(negedge clk);
                if (!arready)
                begin
                    $display("arready did not reopen the cycle after the read data transfer");
                    error_count++;
                end
            end
        end
        arvalid = 1'b0;
        rready = 1'b0;
    endtask

    task report_result;
        $display("Checks finished with %0d errors and %0d timeouts", error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    initial
    begin
        reset_n = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        seed = 32'hee6b;
        error_count = 0;
        timeout_count = 0;
        write_count = 0;
        rand_ready = 1'b1;

        repeat (5) @(negedge clk);
        reset_n = 1'b1;

        // Nothing may be offered in the first cycle out of reset
        if (awready || wready || bvalid || arready || rvalid)
        begin
            $display("A valid or ready output was high in the first cycle after reset");
            error_count++;
        end
        @(negedge clk);

        run_cases();

        rand_ready = 1'b0;
        write_timing_check();
        read_timing_check();

        report_result();
    end

endmodule

// File: csr_subsys.f
design/csr_pkg.sv
design/engine_csr_if.sv
design/axi_lite_csr_bridge.sv
design/csr_mgr.sv
design/accum_engine.sv
design/csr_subsys_top.sv
verification/csr_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the CSR subsystem testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module csr_subsys_tb \
    -f csr_subsys.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcsr_subsys_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
exit 0

// File: verification/csr_cases.txt
# Columns: test name, operation (W writes, R reads), byte address in hex, data in hex
# For R the data column is the expected read value; writes alternate joined and late W
id_read R 000 43535231
num_eng_read R 008 00000002
scratch_reset R 004 00000000
scratch_wr_a W 004 a5a51234
scratch_rd_a R 004 a5a51234
scratch_wr_b W 004 0badf00d
scratch_rd_b R 004 0badf00d
eng0_load W 100 fffffff0
eng0_add1 W 104 00000005
eng0_add2 W 104 00000010
eng0_add3 W 104 00000001
eng0_acc R 100 00000006
eng0_count R 108 00000003
eng1_idle_acc R 200 00000000
eng1_idle_count R 208 00000000
eng1_load W 200 12345678
eng1_add1 W 204 11111111
eng1_acc R 200 23456789
eng1_count R 208 00000001
eng0_keep_acc R 100 00000006
eng0_keep_count R 108 00000003
eng0_reload W 100 00000100
eng0_count_clr R 108 00000000
eng0_acc_new R 100 00000100
eng0_add_rd R 104 00000000
eng1_add_rd R 204 00000000
eng0_spare_rd R 10c 00000000
unmapped_glob R 00c 00000000
unmapped_win R 110 00000000
unmapped_high R 300 00000000
id_wr W 000 ffffffff
id_after_wr R 000 43535231
count_wr W 108 00000055
eng0_count_ro R 108 00000000
eng1_keep_acc R 200 23456789
scratch_final R 004 0badf00d
